// File: include/cpu_settings.svh
`ifndef CPU_SETTINGS_SVH
`define CPU_SETTINGS_SVH

`define CPU_XLEN  32
`define CPU_NREGS 32

// major opcodes
`define CPU_OP_RTYPE 6'h00
`define CPU_OP_BEQ   6'h04
`define CPU_OP_ADDI  6'h08
`define CPU_OP_ANDI  6'h0c
`define CPU_OP_ORI   6'h0d
`define CPU_OP_LUI   6'h0f
`define CPU_OP_LW    6'h23
`define CPU_OP_SW    6'h2b

// R-type function codes
`define CPU_FN_ADD 6'h20
`define CPU_FN_SUB 6'h22
`define CPU_FN_AND 6'h24
`define CPU_FN_OR  6'h25
`define CPU_FN_SLT 6'h2a

`endif

// File: design/cpu_pkg.sv
`default_nettype none

`include "cpu_settings.svh"

package cpu_pkg;

	typedef logic [`CPU_XLEN-1:0] word_t;
	typedef logic [$clog2(`CPU_NREGS)-1:0] reg_idx_t;

	typedef struct packed {
		logic [5:0] op;
		reg_idx_t   rs;
		reg_idx_t   rt;
		reg_idx_t   rd;
		logic [4:0] shamt;
		logic [5:0] funct;
	} r_fmt_t;

	typedef struct packed {
		logic [5:0]  op;
		reg_idx_t    rs;
		reg_idx_t    rt;
		logic [15:0] imm;
	} i_fmt_t;

	// one word read in two field layouts
	typedef union packed {
		r_fmt_t r_fields;
		i_fmt_t i_fields;
	} instr_t;

	typedef enum logic [2:0] {
		ALU_ADD = 3'd0,
		ALU_SUB = 3'd1,
		ALU_AND = 3'd2,
		ALU_OR  = 3'd3,
		ALU_SLT = 3'd4,
		ALU_LUI = 3'd5
	} alu_op_t;

	typedef struct packed {
		logic    mem_write;
		logic    alu_src;       // operand b is the immediate
		logic    alu_reg_write;
		logic    mem_reg_write;
		logic    branch;
		alu_op_t alu_op;
	} ctrl_t;

	typedef struct packed {
		instr_t instr;
		word_t  pc;
	} if_id_t;

	typedef struct packed {
		word_t    pc;
		word_t    rs_data;
		word_t    rt_data;
		reg_idx_t rs;
		reg_idx_t rt;
		reg_idx_t rd;
		word_t    imm;
		ctrl_t    ctrl;
	} id_ex_t;

	typedef struct packed {
		logic     reg_write;
		reg_idx_t rd;
		word_t    result;
	} ex_wb_t;

	typedef struct packed {
		logic     valid;
		reg_idx_t rd;
		word_t    data;
	} retire_t;

endpackage

`default_nettype wire

// File: design/pipe_regs.sv
`timescale 1ns/1ps
`default_nettype none

module if_id_reg
	import cpu_pkg::*;
(
	input  wire logic   clk,
	input  wire logic   reset,
	input  wire logic   we,
	input  wire logic   clear,
	input  wire if_id_t d,
	output if_id_t      q
);

	// all-zero word decodes as a no-op
	always_ff @(posedge clk) begin
		if (reset || clear) begin
			q <= '0;
		end else if (we) begin
			q <= d;
		end
	end

endmodule

module id_ex_reg
	import cpu_pkg::*;
(
	input  wire logic   clk,
	input  wire logic   reset,
	input  wire logic   we,
	input  wire logic   clear,
	input  wire id_ex_t d,
	output id_ex_t      q
);

	always_ff @(posedge clk) begin
		if (reset) begin
			q <= '0;
		end else begin
			if (we) begin
				q <= d;
			end
			if (clear) begin
				q.ctrl <= '0; // bubble with no write and no store
			end
		end
	end

endmodule

module ex_wb_reg
	import cpu_pkg::*;
(
	input  wire logic   clk,
	input  wire logic   reset,
	input  wire logic   we,
	input  wire ex_wb_t d,
	output ex_wb_t      q
);

	always_ff @(posedge clk) begin
		if (reset) begin
			q <= '0;
		end else if (we) begin
			q <= d;
		end
	end

endmodule

`default_nettype wire

// File: design/decoder.sv
`timescale 1ns/1ps
`default_nettype none

`include "cpu_settings.svh"

module decoder
	import cpu_pkg::*;
(
	input  wire instr_t instr,
	output ctrl_t       ctrl,
	output reg_idx_t    rs,
	output reg_idx_t    rt,
	output reg_idx_t    rd,
	output word_t       imm
);

	always_comb begin
		ctrl = '0;
		rs   = instr.i_fields.rs;
		rt   = instr.i_fields.rt;
		rd   = instr.i_fields.rt; // I-type writes rt
		imm  = {{(`CPU_XLEN-16){instr.i_fields.imm[15]}}, instr.i_fields.imm};

		case (instr.i_fields.op)
			`CPU_OP_RTYPE: begin
				rd = instr.r_fields.rd;
				ctrl.alu_reg_write = 1'b1;
				case (instr.r_fields.funct)
					`CPU_FN_ADD: ctrl.alu_op = ALU_ADD;
					`CPU_FN_SUB: ctrl.alu_op = ALU_SUB;
					`CPU_FN_AND: ctrl.alu_op = ALU_AND;
					`CPU_FN_OR:  ctrl.alu_op = ALU_OR;
					`CPU_FN_SLT: ctrl.alu_op = ALU_SLT;
					default:     ctrl = '0;
				endcase
			end
			`CPU_OP_ADDI: begin
				ctrl.alu_src       = 1'b1;
				ctrl.alu_reg_write = 1'b1;
				ctrl.alu_op        = ALU_ADD;
			end
			`CPU_OP_ANDI: begin
				imm = {{(`CPU_XLEN-16){1'b0}}, instr.i_fields.imm};
				ctrl.alu_src       = 1'b1;
				ctrl.alu_reg_write = 1'b1;
				ctrl.alu_op        = ALU_AND;
			end
			`CPU_OP_ORI: begin
				imm = {{(`CPU_XLEN-16){1'b0}}, instr.i_fields.imm};
				ctrl.alu_src       = 1'b1;
				ctrl.alu_reg_write = 1'b1;
				ctrl.alu_op        = ALU_OR;
			end
			`CPU_OP_LUI: begin
				ctrl.alu_src       = 1'b1;
				ctrl.alu_reg_write = 1'b1;
				ctrl.alu_op        = ALU_LUI;
			end
			`CPU_OP_LW: begin
				ctrl.alu_src       = 1'b1;
				ctrl.mem_reg_write = 1'b1;
				ctrl.alu_op        = ALU_ADD; // base + offset
			end
			`CPU_OP_SW: begin
				ctrl.alu_src   = 1'b1;
				ctrl.mem_write = 1'b1;
				ctrl.alu_op    = ALU_ADD;
			end
			`CPU_OP_BEQ: begin
				ctrl.branch = 1'b1;
				ctrl.alu_op = ALU_SUB; // equal when zero
			end
			default: ctrl = '0;
		endcase
	end

endmodule

`default_nettype wire

// File: design/reg_file.sv
`timescale 1ns/1ps
`default_nettype none

module reg_file
	import cpu_pkg::*;
(
	input  wire logic     clk,
	input  wire logic     reset,
	input  wire reg_idx_t ra,
	input  wire reg_idx_t rb,
	output word_t         da,
	output word_t         db,
	input  wire logic     we,
	input  wire reg_idx_t wa,
	input  wire word_t    wd
);

	word_t regs [1 << $bits(reg_idx_t)];

	// entry 0 is never written so it reads as zero
	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < (1 << $bits(reg_idx_t)); i++) begin
				regs[i] <= '0;
			end
		end else if (we && wa != '0) begin
			regs[wa] <= wd;
		end
	end

	// write-first bypass
	assign da = (we && wa != '0 && wa == ra) ? wd : regs[ra];
	assign db = (we && wa != '0 && wa == rb) ? wd : regs[rb];

endmodule

`default_nettype wire

// File: design/alu.sv
`timescale 1ns/1ps
`default_nettype none

module alu
	import cpu_pkg::*;
(
	input  wire alu_op_t op,
	input  wire word_t   a,
	input  wire word_t   b,
	output word_t        y,
	output logic         zero
);

	always_comb begin
		case (op)
			ALU_ADD: y = a + b;
			ALU_SUB: y = a - b;
			ALU_AND: y = a & b;
			ALU_OR:  y = a | b;
			ALU_SLT: y = word_t'($signed(a) < $signed(b));
			ALU_LUI: y = b << 16; // upper half from immediate
			default: y = '0;
		endcase
	end

	assign zero = (y == '0);

endmodule

`default_nettype wire

// File: design/cpu_core.sv
`timescale 1ns/1ps
`default_nettype none

module cpu_core
	import cpu_pkg::*;
(
	input  wire logic  clk,
	input  wire logic  reset,
	input  wire logic  run,
	output word_t      imem_addr,
	input  wire word_t imem_data,
	output word_t      dmem_addr,
	output word_t      dmem_wdata,
	output logic       dmem_we,
	input  wire word_t dmem_rdata,
	output retire_t    retire
);

	word_t    pc;
	word_t    pc_next;
	word_t    br_target;
	logic     flush;

	if_id_t   if_id_d;
	if_id_t   if_id_q;
	id_ex_t   id_ex_d;
	id_ex_t   id_ex_q;
	ex_wb_t   ex_wb_d;
	ex_wb_t   ex_wb_q;

	ctrl_t    dec_ctrl;
	reg_idx_t dec_rs;
	reg_idx_t dec_rt;
	reg_idx_t dec_rd;
	word_t    dec_imm;
	word_t    rf_da;
	word_t    rf_db;

	word_t    op_a;
	word_t    op_b;
	word_t    alu_b;
	word_t    alu_y;
	logic     alu_zero;
	logic     rf_we;

	// fetch
	assign br_target = id_ex_q.pc + word_t'(4) + (id_ex_q.imm << 2);
	assign pc_next   = flush ? br_target : pc + word_t'(4);

	always_ff @(posedge clk) begin
		if (reset) begin
			pc <= '0;
		end else if (run) begin
			pc <= pc_next;
		end
	end

	assign imem_addr = pc;
	assign if_id_d   = '{instr: imem_data, pc: pc};

	if_id_reg u_if_id (
		.clk   (clk),
		.reset (reset),
		.we    (run),
		.clear (flush),
		.d     (if_id_d),
		.q     (if_id_q)
	);

	// decode
	decoder u_decoder (
		.instr (if_id_q.instr),
		.ctrl  (dec_ctrl),
		.rs    (dec_rs),
		.rt    (dec_rt),
		.rd    (dec_rd),
		.imm   (dec_imm)
	);

	assign rf_we = run & ex_wb_q.reg_write; // one write per retire

	reg_file u_reg_file (
		.clk   (clk),
		.reset (reset),
		.ra    (dec_rs),
		.rb    (dec_rt),
		.da    (rf_da),
		.db    (rf_db),
		.we    (rf_we),
		.wa    (ex_wb_q.rd),
		.wd    (ex_wb_q.result)
	);

	assign id_ex_d = '{
		pc:      if_id_q.pc,
		rs_data: rf_da,
		rt_data: rf_db,
		rs:      dec_rs,
		rt:      dec_rt,
		rd:      dec_rd,
		imm:     dec_imm,
		ctrl:    dec_ctrl
	};

	id_ex_reg u_id_ex (
		.clk   (clk),
		.reset (reset),
		.we    (run),
		.clear (flush),
		.d     (id_ex_d),
		.q     (id_ex_q)
	);

	// execute and memory
	// ex_wb only holds writes to nonzero rd
	assign op_a  = (ex_wb_q.reg_write && ex_wb_q.rd == id_ex_q.rs) ? ex_wb_q.result
	                                                                : id_ex_q.rs_data;
	assign op_b  = (ex_wb_q.reg_write && ex_wb_q.rd == id_ex_q.rt) ? ex_wb_q.result
	                                                                : id_ex_q.rt_data;
	assign alu_b = id_ex_q.ctrl.alu_src ? id_ex_q.imm : op_b;

	alu u_alu (
		.op   (id_ex_q.ctrl.alu_op),
		.a    (op_a),
		.b    (alu_b),
		.y    (alu_y),
		.zero (alu_zero)
	);

	assign flush = run & id_ex_q.ctrl.branch & alu_zero;

	assign dmem_addr  = alu_y;
	assign dmem_wdata = op_b;
	assign dmem_we    = run & id_ex_q.ctrl.mem_write;

	always_comb begin
		ex_wb_d.reg_write = (id_ex_q.ctrl.alu_reg_write | id_ex_q.ctrl.mem_reg_write)
		                    & (id_ex_q.rd != '0);
		ex_wb_d.rd        = id_ex_q.rd;
		ex_wb_d.result    = id_ex_q.ctrl.mem_reg_write ? dmem_rdata : alu_y;
	end

	ex_wb_reg u_ex_wb (
		.clk   (clk),
		.reset (reset),
		.we    (run),
		.d     (ex_wb_d),
		.q     (ex_wb_q)
	);

	// write-back
	assign retire = '{valid: rf_we, rd: ex_wb_q.rd, data: ex_wb_q.result};

endmodule

`default_nettype wire

// File: verif/cpu_checker.sv
`timescale 1ns/1ps
`default_nettype none

`include "cpu_settings.svh"

module cpu_checker
	import cpu_pkg::*;
(
	input wire logic    clk,
	input wire logic    reset,
	input wire word_t   imem_addr,
	input wire word_t   dmem_addr,
	input wire word_t   dmem_wdata,
	input wire logic    dmem_we,
	input wire retire_t retire
);

	typedef struct packed {
		logic  valid;
		word_t addr;
		word_t data;
	} store_t;

	typedef struct packed {
		retire_t wr;
		store_t  st;
	} step_t;

	word_t   prog [256]; // filled by the testbench
	word_t   mem [256];
	word_t   regs [`CPU_NREGS];
	word_t   pc;
	retire_t exp_wr [$];
	store_t  exp_st [$];
	retire_t want_wr;
	store_t  want_st;
	string   test_name;
	logic    active;
	logic    idle_only; // run held low so nothing may move
	int      test_errs;
	int      n_pass;
	int      n_fail;

	initial begin
		active    = 1'b0;
		idle_only = 1'b0;
		test_errs = 0;
		n_pass    = 0;
		n_fail    = 0;
	end

	// one instruction on the model state
	function automatic step_t iss_step();
		instr_t ins;
		step_t  s;
		word_t  a;
		word_t  b;
		word_t  sx;
		word_t  ea;
		ins = prog[pc[9:2]];
		s   = '0;
		a   = regs[ins.i_fields.rs];
		b   = regs[ins.i_fields.rt];
		sx  = {{16{ins.i_fields.imm[15]}}, ins.i_fields.imm};
		ea  = a + sx;
		s.wr.valid = 1'b1;
		s.wr.rd    = ins.i_fields.rt;
		pc = pc + 4;
		case (ins.i_fields.op)
			`CPU_OP_RTYPE: begin
				s.wr.rd = ins.r_fields.rd;
				case (ins.r_fields.funct)
					`CPU_FN_ADD: s.wr.data = a + b;
					`CPU_FN_SUB: s.wr.data = a - b;
					`CPU_FN_AND: s.wr.data = a & b;
					`CPU_FN_OR:  s.wr.data = a | b;
					`CPU_FN_SLT: s.wr.data = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
					default:     s.wr.valid = 1'b0;
				endcase
			end
			`CPU_OP_ADDI: s.wr.data = a + sx;
			`CPU_OP_ANDI: s.wr.data = a & {16'h0000, ins.i_fields.imm};
			`CPU_OP_ORI:  s.wr.data = a | {16'h0000, ins.i_fields.imm};
			`CPU_OP_LUI:  s.wr.data = {ins.i_fields.imm, 16'h0000};
			`CPU_OP_LW:   s.wr.data = mem[ea[9:2]];
			`CPU_OP_SW: begin
				s.wr.valid = 1'b0;
				s.st = '{valid: 1'b1, addr: ea, data: b};
				mem[ea[9:2]] = b;
			end
			`CPU_OP_BEQ: begin
				s.wr.valid = 1'b0;
				if (a == b) pc = pc + (sx << 2);
			end
			default: s.wr.valid = 1'b0;
		endcase
		if (s.wr.rd == '0) s.wr.valid = 1'b0; // x0 stays zero
		if (s.wr.valid) regs[s.wr.rd] = s.wr.data;
		return s;
	endfunction

	task automatic begin_test(input string name, input logic idle);
		step_t s;
		word_t last_pc;
		test_name = name;
		idle_only = idle;
		test_errs = 0;
		exp_wr.delete();
		exp_st.delete();
		pc = '0;
		for (int i = 0; i < `CPU_NREGS; i++) regs[i] = '0;
		// model runs up to the closing self-branch
		for (int n = 0; n < 4096; n++) begin
			last_pc = pc;
			s = iss_step();
			if (s.wr.valid) exp_wr.push_back(s.wr);
			if (s.st.valid) exp_st.push_back(s.st);
			if (pc == last_pc) break;
		end
		active = 1'b1;
	endtask

	function automatic int pending();
		return exp_wr.size() + exp_st.size();
	endfunction

	always @(negedge clk) begin
		if (!reset && active) begin
			if (idle_only && imem_addr !== '0) begin
				$display("FAIL %s imem_addr expected %h actual %h", test_name, 32'h0, imem_addr);
				test_errs++;
			end
			if (retire.valid) begin
				if (exp_wr.size() == 0) begin
					$display("%s: retire to x%0d with no write left in the model",
						test_name, retire.rd);
					test_errs++;
				end else begin
					want_wr = exp_wr.pop_front();
					if (want_wr !== retire) begin
						$display("FAIL %s retire expected x%0d=%h actual x%0d=%h", test_name,
							want_wr.rd, want_wr.data, retire.rd, retire.data);
						test_errs++;
					end
				end
			end
			if (dmem_we) begin
				if (exp_st.size() == 0) begin
					$display("%s: store to %h with no store left in the model",
						test_name, dmem_addr);
					test_errs++;
				end else begin
					want_st = exp_st.pop_front();
					if (want_st.addr !== dmem_addr || want_st.data !== dmem_wdata) begin
						$display("FAIL %s store expected [%h]=%h actual [%h]=%h", test_name,
							want_st.addr, want_st.data, dmem_addr, dmem_wdata);
						test_errs++;
					end
				end
			end
		end
	end

	task automatic end_test();
		if (exp_wr.size() != 0) begin
			$display("%s: %0d register writes never retired before the timeout",
				test_name, exp_wr.size());
			test_errs++;
		end
		if (exp_st.size() != 0) begin
			$display("%s: %0d stores never reached the data port", test_name, exp_st.size());
			test_errs++;
		end
		if (test_errs == 0) begin
			n_pass++;
			$display("test %s: passed", test_name);
		end else begin
			n_fail++;
			$display("test %s: failed with %0d errors", test_name, test_errs);
		end
		active = 1'b0;
	endtask

endmodule

`default_nettype wire

// File: verif/tb_cpu.sv
`timescale 1ns/1ps
`default_nettype none

`include "cpu_settings.svh"

module tb_cpu
	import cpu_pkg::*;
();

	localparam word_t self_loop = {`CPU_OP_BEQ, 5'd0, 5'd0, 16'hffff}; // beq x0, x0, -1

	logic    clk;
	logic    reset;
	logic    run;
	word_t   imem_addr;
	word_t   imem_data;
	word_t   dmem_addr;
	word_t   dmem_wdata;
	word_t   dmem_rdata;
	logic    dmem_we;
	retire_t retire;
	word_t   imem [256];
	word_t   dmem [256];
	int      n_prog;

	cpu_core u_dut (.*);

	cpu_checker u_chk (.*);

	// word addressed with combinational read
	assign imem_data  = imem[imem_addr[9:2]];
	assign dmem_rdata = dmem[dmem_addr[9:2]];

	always @(posedge clk) begin
		if (dmem_we) dmem[dmem_addr[9:2]] <= dmem_wdata;
	end

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	function automatic word_t rtype_word(input logic [5:0] fn, input logic [4:0] rd,
		input logic [4:0] rs, input logic [4:0] rt);
		return {`CPU_OP_RTYPE, rs, rt, rd, 5'd0, fn};
	endfunction

	function automatic word_t itype_word(input logic [5:0] op, input logic [4:0] rt,
		input logic [4:0] rs, input logic [15:0] imm);
		return {op, rs, rt, imm};
	endfunction

	// x0..x7 only so dependencies are frequent
	function automatic word_t random_instr(input logic with_mem);
		logic [4:0]  d;
		logic [4:0]  s;
		logic [4:0]  t;
		logic [15:0] k;
		word_t       w;
		d = 5'($urandom % 8);
		s = 5'($urandom % 8);
		t = 5'($urandom % 8);
		k = 16'($urandom);
		case ($urandom % (with_mem ? 11 : 9))
			0: w = rtype_word(`CPU_FN_ADD, d, s, t);
			1: w = rtype_word(`CPU_FN_SUB, d, s, t);
			2: w = rtype_word(`CPU_FN_AND, d, s, t);
			3: w = rtype_word(`CPU_FN_OR, d, s, t);
			4: w = rtype_word(`CPU_FN_SLT, d, s, t);
			5: w = itype_word(`CPU_OP_ADDI, d, s, k);
			6: w = itype_word(`CPU_OP_ANDI, d, s, k);
			7: w = itype_word(`CPU_OP_ORI, d, s, k);
			8: w = itype_word(`CPU_OP_LUI, d, 5'd0, k);
			9: w = itype_word(`CPU_OP_SW, t, 5'd0, {8'h00, k[5:0], 2'b00});
			default: w = itype_word(`CPU_OP_LW, d, 5'd0, {8'h00, k[5:0], 2'b00});
		endcase
		return w;
	endfunction

	task automatic append_instr(input word_t w);
		imem[n_prog] = w;
		u_chk.prog[n_prog] = w;
		n_prog++;
	endtask

	// program and data image load while reset is high
	task automatic enter_reset();
		@(posedge clk);
		#1;
		reset  = 1'b1;
		run    = 1'b0;
		n_prog = 0;
		for (int i = 0; i < 256; i++) begin
			imem[i] = '0;
			u_chk.prog[i] = '0;
			dmem[i] = 32'h9e37_79b9 * (i + 1);
			u_chk.mem[i] = dmem[i];
		end
	endtask

	task automatic leave_reset();
		repeat (2) @(posedge clk);
		#1;
		reset = 1'b0;
	endtask

	task automatic run_program(input string name, input logic drop_run);
		int cycles;
		leave_reset();
		u_chk.begin_test(name, 1'b0);
		cycles = 0;
		while (u_chk.pending() != 0 && cycles < 600) begin
			run = drop_run ? ($urandom % 3 != 0) : 1'b1;
			@(posedge clk);
			#1;
			cycles++;
		end
		run = 1'b1;
		for (int i = 0; i < 10; i++) begin // catch stray retires
			@(posedge clk);
			#1;
		end
		u_chk.end_test();
	endtask

	initial begin
		reset  = 1'b1;
		run    = 1'b0;
		n_prog = 0;
		void'($urandom(32'h82f2_0d16));

		enter_reset();
		append_instr(self_loop);
		leave_reset();
		u_chk.begin_test("reset", 1'b1);
		for (int i = 0; i < 8; i++) begin
			@(posedge clk);
			#1;
		end
		u_chk.end_test();

		enter_reset();
		append_instr(itype_word(`CPU_OP_LUI, 5'd1, 5'd0, 16'h8001));
		append_instr(itype_word(`CPU_OP_ADDI, 5'd2, 5'd0, 16'd5));
		append_instr(rtype_word(`CPU_FN_SLT, 5'd3, 5'd1, 5'd2)); // negative < 5
		append_instr(rtype_word(`CPU_FN_SLT, 5'd4, 5'd2, 5'd1));
		for (int i = 0; i < 32; i++) append_instr(random_instr(1'b0));
		append_instr(self_loop);
		run_program("alu", 1'b0);

		enter_reset();
		append_instr(itype_word(`CPU_OP_ADDI, 5'd1, 5'd0, 16'd5));
		append_instr(itype_word(`CPU_OP_ADDI, 5'd2, 5'd1, 16'd3));
		append_instr(rtype_word(`CPU_FN_ADD, 5'd3, 5'd1, 5'd2));
		append_instr(rtype_word(`CPU_FN_SUB, 5'd4, 5'd3, 5'd1));
		append_instr(rtype_word(`CPU_FN_OR, 5'd5, 5'd4, 5'd3));
		append_instr(rtype_word(`CPU_FN_SLT, 5'd6, 5'd1, 5'd5));
		append_instr(self_loop);
		run_program("forwarding", 1'b0);

		enter_reset();
		append_instr(itype_word(`CPU_OP_ADDI, 5'd1, 5'd0, 16'h0040));
		append_instr(itype_word(`CPU_OP_ADDI, 5'd2, 5'd0, 16'hff85));
		append_instr(itype_word(`CPU_OP_SW, 5'd2, 5'd1, 16'd0));
		append_instr(itype_word(`CPU_OP_LW, 5'd3, 5'd1, 16'd0));
		append_instr(rtype_word(`CPU_FN_ADD, 5'd4, 5'd3, 5'd3));
		append_instr(itype_word(`CPU_OP_SW, 5'd4, 5'd1, 16'd4));
		append_instr(itype_word(`CPU_OP_LW, 5'd5, 5'd1, 16'd8));
		append_instr(itype_word(`CPU_OP_LW, 5'd6, 5'd1, 16'd4));
		append_instr(self_loop);
		run_program("memory", 1'b0);

		enter_reset();
		append_instr(itype_word(`CPU_OP_ADDI, 5'd1, 5'd0, 16'd7));
		append_instr(itype_word(`CPU_OP_ADDI, 5'd2, 5'd0, 16'd7));
		append_instr(itype_word(`CPU_OP_BEQ, 5'd2, 5'd1, 16'd2)); // taken
		append_instr(itype_word(`CPU_OP_ADDI, 5'd3, 5'd0, 16'd1));
		append_instr(itype_word(`CPU_OP_ADDI, 5'd4, 5'd0, 16'd2));
		append_instr(itype_word(`CPU_OP_ADDI, 5'd5, 5'd0, 16'd3));
		append_instr(itype_word(`CPU_OP_BEQ, 5'd5, 5'd1, 16'd1)); // falls through
		append_instr(itype_word(`CPU_OP_ADDI, 5'd6, 5'd0, 16'd4));
		append_instr(self_loop);
		run_program("branches", 1'b0);

		enter_reset();
		for (int i = 0; i < 48; i++) append_instr(random_instr(1'b1));
		append_instr(self_loop);
		run_program("run_control", 1'b1);

		$display("tests passed: %0d, tests failed: %0d", u_chk.n_pass, u_chk.n_fail);
		if (u_chk.n_fail == 0) begin
			$display("NO ERRORS");
		end else begin
			$display("ERRORS FOUND");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: flist.f
+incdir+include
design/cpu_pkg.sv
design/pipe_regs.sv
design/decoder.sv
design/reg_file.sv
design/alu.sv
design/cpu_core.sv
verif/cpu_checker.sv
verif/tb_cpu.sv
